// File: Makefile
# Verilator flow for the Path ORAM backend
TOP := oramBackendTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# Error limit raised so a failed property reaches the testbench verdict
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/oramBackendTb.sv
// Testbench of the Path ORAM backend
// DRAM model with random latency and stalls, shadow memory reference and checks
`timescale 1ns/100ps
`default_nettype none

`include "oram_macros.svh"

module oramBackendTb;

	localparam int Period = 4;
	localparam int BW = $bits(oramPkg::bucket_t);
	localparam int NumBuckets = (1 << (`ORAM_L + 1)) - 1;
	localparam int NumBlocks = 1 << `ORAM_U;
	localparam int RandomCmds = 300;
	localparam int StallCmds = 60;
	localparam int TotalCmds = 2 + 2 * NumBlocks + RandomCmds + StallCmds;
	localparam int CmdCycles = 200;
	localparam logic [BW-1:0] Key = `CIPHER_KEY;

	typedef logic [`ORAM_L-1:0] leaf_t;
	typedef logic [`ORAM_U-1:0] paddr_t;
	typedef logic [`ORAM_DW-1:0] data_t;
	typedef logic [`ORAM_AW-1:0] addr_t;

	logic Clock;
	logic arstN;
	oramPkg::oramCmd_t Command;
	logic CommandValid;
	logic CommandReady;
	data_t LoadData;
	logic LoadValid;
	oramPkg::dramCmd_t DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	oramPkg::dramWord_u DRAMReadData;
	logic DRAMReadDataValid;
	oramPkg::dramWord_u DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;

	// Bucket i lives at mem[i-1]
	oramPkg::dramWord_u mem [NumBuckets];
	data_t shadowData [NumBlocks];
	leaf_t shadowLeaf [NumBlocks];
	// Expected loads and DRAM commands in issue order
	data_t loadQ [$];
	oramPkg::dramCmd_t pathQ [$];
	string testName;
	logic stallMode;

	oramBackend dut0 (
		.Clock              (Clock),
		.arstN              (arstN),
		.Command            (Command),
		.CommandValid       (CommandValid),
		.CommandReady       (CommandReady),
		.LoadData           (LoadData),
		.LoadValid          (LoadValid),
		.DRAMCommand        (DRAMCommand),
		.DRAMCommandValid   (DRAMCommandValid),
		.DRAMCommandReady   (DRAMCommandReady),
		.DRAMReadData       (DRAMReadData),
		.DRAMReadDataValid  (DRAMReadDataValid),
		.DRAMWriteData      (DRAMWriteData),
		.DRAMWriteDataValid (DRAMWriteDataValid),
		.DRAMWriteDataReady (DRAMWriteDataReady)
	);

	bind oramBackend oramBackend_properties props0 (
		.Clock              (Clock),
		.arstN              (arstN),
		.CommandValid       (CommandValid),
		.CommandReady       (CommandReady),
		.LoadValid          (LoadValid),
		.DRAMCommand        (DRAMCommand),
		.DRAMCommandValid   (DRAMCommandValid),
		.DRAMCommandReady   (DRAMCommandReady),
		.DRAMWriteData      (DRAMWriteData),
		.DRAMWriteDataValid (DRAMWriteDataValid),
		.DRAMWriteDataReady (DRAMWriteDataReady)
	);

	// ------------------------------------------------------------------------
	// Reference model and checks
	// ------------------------------------------------------------------------

	// Key rotated left by the index, then the index tiled over the word
	function automatic logic [BW-1:0] keyStream(input int idx);
		logic [BW-1:0] ks;
		ks = (Key << idx) | (Key >> (BW - idx));
		for (int i = 0; i < BW; i++)
			ks[i] = ks[i] ^ idx[i % `ORAM_AW];
		return ks;
	endfunction

	function automatic int pathIndex(input int leaf, input int lvl);
		int idx;
		idx = 1;
		for (int i = 0; i < lvl; i++)
			idx = 2 * idx + ((leaf >> (`ORAM_L - 1 - i)) & 1);
		return idx;
	endfunction

	// Returns the old data of the block and applies the command to the shadow
	function automatic data_t refAccess(input oramPkg::oramCmd_t cmd);
		data_t old;
		old = shadowData[cmd.paddr];
		if (cmd.write)
			shadowData[cmd.paddr] = cmd.storeData;
		shadowLeaf[cmd.paddr] = cmd.remappedLeaf;
		return old;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual)
			failRun($sformatf("mismatch in %s, %s: expected %0h, actual %0h",
				testName, what, expected, actual));
	endtask

	// Outgoing word must be ciphertext holding a block on its own path
	task automatic storeWrite(input int addr, input oramPkg::dramWord_u word);
		oramPkg::dramWord_u plain;
		logic onPath;
		plain.raw = word.raw ^ keyStream(addr);
		onPath = 1'b0;
		for (int l = 0; l <= `ORAM_L; l++)
			if (pathIndex(int'(plain.bucket.leaf), l) == addr)
				onPath = 1'b1;
		if (plain.raw == word.raw)
			failRun($sformatf("in %s bucket %0d was written unencrypted", testName, addr));
		if (plain.bucket.valid) begin
			if (!onPath)
				failRun($sformatf("in %s bucket %0d holds a block off its path",
					testName, addr));
			checkValue("written data", 64'(shadowData[plain.bucket.paddr]),
				64'(plain.bucket.data));
			checkValue("written leaf", 64'(shadowLeaf[plain.bucket.paddr]),
				64'(plain.bucket.leaf));
		end
		mem[addr - 1] = word;
	endtask

	// Expectations are queued before the command goes out
	task automatic runCommand(input logic write, input paddr_t paddr, input data_t data);
		oramPkg::oramCmd_t cmd;
		oramPkg::dramCmd_t step;
		data_t expected;
		cmd.write = write;
		cmd.paddr = paddr;
		cmd.currentLeaf = shadowLeaf[paddr];
		cmd.remappedLeaf = leaf_t'($urandom);
		cmd.storeData = data;
		expected = refAccess(cmd);
		if (!write)
			loadQ.push_back(expected);
		for (int l = 0; l <= 2 * `ORAM_L + 1; l++) begin
			step.write = (l > `ORAM_L);
			step.addr = addr_t'(pathIndex(int'(cmd.currentLeaf),
				step.write ? 2 * `ORAM_L + 1 - l : l));
			pathQ.push_back(step);
		end
		Command = cmd;
		CommandValid = 1'b1;
		@(negedge Clock);
		while (!CommandReady)
			@(negedge Clock);
		@(posedge Clock);
		#1;
		CommandValid = 1'b0;
		// CommandReady comes back after the root write
		@(negedge Clock);
		while (!CommandReady)
			@(negedge Clock);
		@(posedge Clock);
		#1;
	endtask

	always @(negedge Clock) begin
		if (arstN && LoadValid) begin
			if (loadQ.size() == 0)
				failRun($sformatf("in %s LoadValid pulsed with no read pending", testName));
			else
				checkValue("load data", 64'(loadQ.pop_front()), 64'(LoadData));
		end
		if (dut0.props0.failCount != 0)
			failRun($sformatf("in %s a handshake or reset property failed", testName));
	end

	// ------------------------------------------------------------------------
	// Clock, DRAM model and watchdog
	// ------------------------------------------------------------------------

	initial begin
		Clock = 1'b0;
		forever #(Period / 2) Clock = ~Clock;
	end

	initial begin
		#(Period * (CmdCycles * TotalCmds + 100));
		failRun($sformatf("timeout in %s, the backend stopped making progress", testName));
	end

	initial begin : dramModel
		logic cmdFire;
		logic wrFire;
		oramPkg::dramCmd_t cmdSeen;
		oramPkg::dramWord_u wordSeen;
		int readQ [$];
		int dueQ [$];
		int wrAddrQ [$];
		int cyc;
		int stall;
		DRAMCommandReady = 1'b0;
		DRAMWriteDataReady = 1'b0;
		DRAMReadDataValid = 1'b0;
		DRAMReadData = '0;
		cyc = 0;
		stall = 0;
		for (int i = 0; i < NumBuckets; i++)
			mem[i] = '0;
		// Empty buckets start as encrypted zero words
		for (int i = 0; i < NumBuckets; i++)
			mem[i].raw = keyStream(i + 1);
		forever begin
			@(negedge Clock);
			cmdFire = DRAMCommandValid && DRAMCommandReady;
			wrFire = DRAMWriteDataValid && DRAMWriteDataReady;
			cmdSeen = DRAMCommand;
			wordSeen = DRAMWriteData;
			@(posedge Clock);
			#1;
			cyc++;
			if (cmdFire) begin
				if (pathQ.size() == 0)
					failRun($sformatf("in %s a DRAM command came with none expected", testName));
				else
					checkValue("DRAM command", 64'(pathQ.pop_front()), 64'(cmdSeen));
				if (cmdSeen.write) begin
					wrAddrQ.push_back(int'(cmdSeen.addr));
				end else begin
					readQ.push_back(int'(cmdSeen.addr));
					dueQ.push_back(cyc + 1 + int'($urandom % 4));
				end
			end
			if (wrFire) begin
				if (wrAddrQ.size() == 0)
					failRun($sformatf("in %s write data came before its command", testName));
				else
					storeWrite(wrAddrQ.pop_front(), wordSeen);
			end
			// Read words return in command order
			DRAMReadDataValid = 1'b0;
			if (readQ.size() != 0 && dueQ[0] <= cyc) begin
				DRAMReadData = mem[readQ.pop_front() - 1];
				void'(dueQ.pop_front());
				DRAMReadDataValid = 1'b1;
			end
			if (stall > 0)
				stall--;
			else if (stallMode && ($urandom % 6 == 0))
				stall = 1 + int'($urandom % 12);
			DRAMCommandReady = (stall == 0) && ($urandom % 4 != 0);
			DRAMWriteDataReady = (stall == 0) && ($urandom % 4 != 0);
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		void'($urandom(32'h1b32_7b76));
		arstN = 1'b0;
		Command = '0;
		CommandValid = 1'b0;
		stallMode = 1'b0;
		testName = "reset";
		for (int p = 0; p < NumBlocks; p++) begin
			shadowData[p] = '0;
			shadowLeaf[p] = leaf_t'($urandom);
		end
		repeat (4) @(posedge Clock);
		#1;
		arstN = 1'b1;

		testName = "unwritten";
		runCommand(1'b0, paddr_t'(0), '0);
		runCommand(1'b0, paddr_t'(5), '0);

		testName = "writeRead";
		for (int p = 0; p < NumBlocks; p++) begin
			runCommand(1'b1, paddr_t'(p), data_t'($urandom));
			runCommand(1'b0, paddr_t'(p), '0);
		end

		testName = "random";
		repeat (RandomCmds)
			runCommand(1'($urandom), paddr_t'($urandom), data_t'($urandom));

		testName = "backpressure";
		stallMode = 1'b1;
		repeat (StallCmds)
			runCommand(1'($urandom), paddr_t'($urandom), data_t'($urandom));

		if (loadQ.size() != 0 || pathQ.size() != 0) begin
			failRun("loads or DRAM commands still expected at the end of the run");
		end else if (dut0.props0.failCount != 0) begin
			failRun("a handshake or reset property failed on the last cycle");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/oramBackend_properties.sv
// Handshake and reset properties of the Path ORAM backend
// Bound into the backend top level
`timescale 1ns/100ps
`default_nettype none

module oramBackend_properties (
	input wire                     Clock,
	input wire                     arstN,
	input wire                     CommandValid,
	input wire                     CommandReady,
	input wire                     LoadValid,
	input wire oramPkg::dramCmd_t  DRAMCommand,
	input wire                     DRAMCommandValid,
	input wire                     DRAMCommandReady,
	input wire oramPkg::dramWord_u DRAMWriteData,
	input wire                     DRAMWriteDataValid,
	input wire                     DRAMWriteDataReady
);

	// Failed property count, watched by the testbench
	int failCount = 0;

	// Idle outputs on the first cycle out of reset
	resetIdle: assert property (@(posedge Clock) $rose(arstN) |->
		CommandReady && !DRAMCommandValid && !DRAMWriteDataValid && !LoadValid)
		else begin
			$error("outputs not idle after reset");
			failCount++;
		end

	cmdHeld: assert property (@(posedge Clock) disable iff (!arstN)
		DRAMCommandValid && !DRAMCommandReady |=> DRAMCommandValid && $stable(DRAMCommand))
		else begin
			$error("DRAM command dropped or changed before ready");
			failCount++;
		end

	writeHeld: assert property (@(posedge Clock) disable iff (!arstN)
		DRAMWriteDataValid && !DRAMWriteDataReady |=>
		DRAMWriteDataValid && $stable(DRAMWriteData))
		else begin
			$error("DRAM write data dropped or changed before ready");
			failCount++;
		end

	// A load only belongs to a command in flight
	loadInside: assert property (@(posedge Clock) disable iff (!arstN)
		LoadValid |-> !CommandReady)
		else begin
			$error("LoadValid outside a command");
			failCount++;
		end

	acceptDrop: assert property (@(posedge Clock) disable iff (!arstN)
		CommandValid && CommandReady |=> !CommandReady)
		else begin
			$error("CommandReady still high after acceptance");
			failCount++;
		end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/oramPkg.sv
logic/pathAddrGen.sv
logic/blockStash.sv
logic/bucketCipher.sv
logic/oramBackend.sv
bench/oramBackend_properties.sv
bench/oramBackendTb.sv

// File: include/oram_macros.svh
// Path ORAM backend configuration
// Tree shape, field widths, stash size and bucket cipher key
`ifndef ORAM_MACROS_SVH
`define ORAM_MACROS_SVH

// Levels below the root, so 2**L leaves
`define ORAM_L 3

// Width of a level index, 0 (root) to L (leaf)
`define ORAM_LW ($clog2(`ORAM_L + 1))

// Block address and payload
`define ORAM_U 3
`define ORAM_DW 32

// DRAM address holds bucket indices 1 to 2**(L+1)-1
`define ORAM_AW 4

// Large enough for every block at once
`define STASH_N 16

// Keystream seed, one bit per bit of a DRAM word
`define CIPHER_KEY 39'h3A_5C1E_96B7

`endif

// File: logic/blockStash.sv
// Path ORAM stash
// Absorbs path blocks, serves the load or store, remaps and evicts per level
`timescale 1ns/100ps
`default_nettype none

`include "oram_macros.svh"

module blockStash (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire oramPkg::oramCmd_t    activeCmd,
	input  wire oramPkg::bucket_t     bucketIn,
	input  wire                       bucketInValid,
	input  wire                       serveNow,
	input  wire                       evictNow,
	input  wire [`ORAM_LW-1:0]        level,
	output oramPkg::bucket_t          bucketOut,
	output logic [`ORAM_DW-1:0]       LoadData,
	output logic                      LoadValid
);

	localparam int IdxW = $clog2(`STASH_N);

	oramPkg::bucket_t mem [`STASH_N];
	logic [`STASH_N-1:0] used;

	logic [IdxW-1:0] freeIdx;
	logic [IdxW-1:0] hitIdx;
	logic [IdxW-1:0] evictIdx;
	logic [IdxW-1:0] serveIdx;
	logic freeFound;
	logic hitFound;
	logic evictFound;

	logic [`ORAM_L-1:0] pathMask;
	logic [`ORAM_DW-1:0] curData;
	logic absorb;
	logic serveOk;

	// Top "level" leaf bits must agree with the current path
	assign pathMask = ~({`ORAM_L{1'b1}} >> level);

	// --------------------------------------------------------------------------
	// Searches, lowest entry wins
	// --------------------------------------------------------------------------

	always_comb begin
		freeFound = 1'b0;
		freeIdx = '0;
		hitFound = 1'b0;
		hitIdx = '0;
		evictFound = 1'b0;
		evictIdx = '0;
		for (int i = `STASH_N - 1; i >= 0; i--) begin
			if (!used[i]) begin
				freeFound = 1'b1;
				freeIdx = IdxW'(i);
			end
			if (used[i] && (mem[i].paddr == activeCmd.paddr)) begin
				hitFound = 1'b1;
				hitIdx = IdxW'(i);
			end
			if (used[i] && (((mem[i].leaf ^ activeCmd.currentLeaf) & pathMask) == '0)) begin
				evictFound = 1'b1;
				evictIdx = IdxW'(i);
			end
		end
	end

	// Only real blocks from the path take an entry
	assign absorb = bucketInValid && bucketIn.valid && freeFound;

	// A missing block is created with zero data
	assign serveIdx = hitFound ? hitIdx : freeIdx;
	assign serveOk = serveNow && (hitFound || freeFound);
	assign curData = hitFound ? mem[hitIdx].data : '0;

	// --------------------------------------------------------------------------
	// Storage
	// --------------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (absorb) begin
			mem[freeIdx] <= bucketIn;
		end else if (serveOk) begin
			mem[serveIdx] <= '{valid: 1'b1,
				paddr: activeCmd.paddr,
				leaf: activeCmd.remappedLeaf,
				data: activeCmd.write ? activeCmd.storeData : curData};
		end
		if (serveNow)
			LoadData <= curData;
		// Empty bucket when nothing fits this level
		if (evictNow)
			bucketOut <= evictFound ? mem[evictIdx] : '0;
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			used <= '0;
			LoadValid <= 1'b0;
		end else begin
			LoadValid <= serveNow && !activeCmd.write;
			if (absorb)
				used[freeIdx] <= 1'b1;
			if (serveOk)
				used[serveIdx] <= 1'b1;
			if (evictNow && evictFound)
				used[evictIdx] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/bucketCipher.sv
// Bucket cipher between the stash and DRAM
// XOR keystream keyed by bucket index, registered in both directions
`timescale 1ns/100ps
`default_nettype none

`include "oram_macros.svh"

module bucketCipher (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire oramPkg::dramWord_u   DRAMReadData,
	input  wire                       DRAMReadDataValid,
	input  wire [`ORAM_AW-1:0]        readAddr,
	output oramPkg::bucket_t          bucketIn,
	output logic                      bucketInValid,
	input  wire oramPkg::bucket_t     bucketOut,
	input  wire [`ORAM_AW-1:0]        writeAddr,
	input  wire                       writeReq,
	output oramPkg::dramWord_u        DRAMWriteData,
	output logic                      DRAMWriteDataValid,
	input  wire                       DRAMWriteDataReady,
	output logic                      writeDone
);

	localparam int BW = $bits(oramPkg::bucket_t);
	localparam int RepN = BW / `ORAM_AW + 1;
	localparam logic [BW-1:0] Key = `CIPHER_KEY;

	oramPkg::dramWord_u plainIn;

	// Key rotated left by the index, XOR the index tiled over the word
	function automatic logic [BW-1:0] keyStream(input logic [`ORAM_AW-1:0] addr);
		logic [2*BW-1:0] doubled;
		logic [BW-1:0] tiled;
		doubled = {Key, Key} << addr;
		tiled = BW'({RepN{addr}});
		return doubled[2*BW-1:BW] ^ tiled;
	endfunction

	assign plainIn.raw = DRAMReadData.raw ^ keyStream(readAddr);
	assign writeDone = DRAMWriteDataValid && DRAMWriteDataReady;

	always_ff @(posedge Clock) begin
		if (DRAMReadDataValid)
			bucketIn <= plainIn.bucket;
		// Held until the DRAM takes it
		if (writeReq)
			DRAMWriteData.raw <= bucketOut ^ keyStream(writeAddr);
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			bucketInValid <= 1'b0;
			DRAMWriteDataValid <= 1'b0;
		end else begin
			bucketInValid <= DRAMReadDataValid;
			if (writeReq)
				DRAMWriteDataValid <= 1'b1;
			else if (writeDone)
				DRAMWriteDataValid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/oramBackend.sv
// Path ORAM backend top level
// Address generation, stash and bucket cipher on one command at a time
`timescale 1ns/100ps
`default_nettype none

`include "oram_macros.svh"

module oramBackend (
	input  wire                       Clock,
	input  wire                       arstN,

	input  wire oramPkg::oramCmd_t    Command,
	input  wire                       CommandValid,
	output logic                      CommandReady,

	output logic [`ORAM_DW-1:0]       LoadData,
	output logic                      LoadValid,

	output oramPkg::dramCmd_t         DRAMCommand,
	output logic                      DRAMCommandValid,
	input  wire                       DRAMCommandReady,

	input  wire oramPkg::dramWord_u   DRAMReadData,
	input  wire                       DRAMReadDataValid,

	output oramPkg::dramWord_u        DRAMWriteData,
	output logic                      DRAMWriteDataValid,
	input  wire                       DRAMWriteDataReady
);

	oramPkg::oramCmd_t activeCmd;
	oramPkg::bucket_t bucketIn;
	oramPkg::bucket_t bucketOut;

	logic bucketInValid;
	logic readLevel;
	logic writeLevel;
	logic [`ORAM_LW-1:0] level;
	logic evictNow;
	logic writeReq;
	logic writeDone;
	logic pathDone;

	logic [`ORAM_AW-1:0] levelAddr;
	logic [`ORAM_AW-1:0] readAddr;
	logic [`ORAM_AW-1:0] writeAddr;

	// Bucket at the current walk level, split by phase for the cipher
	assign levelAddr = oramPkg::bucketIdx(activeCmd.currentLeaf, level);
	assign readAddr = readLevel ? levelAddr : '0;
	assign writeAddr = writeLevel ? levelAddr : '0;

	// --------------------------------------------------------------------------
	// Blocks
	// --------------------------------------------------------------------------

	pathAddrGen addrGen0 (
		.Clock            (Clock),
		.arstN            (arstN),
		.Command          (Command),
		.CommandValid     (CommandValid),
		.CommandReady     (CommandReady),
		.activeCmd        (activeCmd),
		.DRAMCommand      (DRAMCommand),
		.DRAMCommandValid (DRAMCommandValid),
		.DRAMCommandReady (DRAMCommandReady),
		.readWordSeen     (DRAMReadDataValid),
		.readLevel        (readLevel),
		.writeLevel       (writeLevel),
		.level            (level),
		.evictNow         (evictNow),
		.writeReq         (writeReq),
		.writeDone        (writeDone),
		.pathDone         (pathDone)
	);

	blockStash stash0 (
		.Clock         (Clock),
		.arstN         (arstN),
		.activeCmd     (activeCmd),
		.bucketIn      (bucketIn),
		.bucketInValid (bucketInValid),
		.serveNow      (pathDone),
		.evictNow      (evictNow),
		.level         (level),
		.bucketOut     (bucketOut),
		.LoadData      (LoadData),
		.LoadValid     (LoadValid)
	);

	bucketCipher cipher0 (
		.Clock              (Clock),
		.arstN              (arstN),
		.DRAMReadData       (DRAMReadData),
		.DRAMReadDataValid  (DRAMReadDataValid),
		.readAddr           (readAddr),
		.bucketIn           (bucketIn),
		.bucketInValid      (bucketInValid),
		.bucketOut          (bucketOut),
		.writeAddr          (writeAddr),
		.writeReq           (writeReq),
		.DRAMWriteData      (DRAMWriteData),
		.DRAMWriteDataValid (DRAMWriteDataValid),
		.DRAMWriteDataReady (DRAMWriteDataReady),
		.writeDone          (writeDone)
	);

endmodule

`default_nettype wire

// File: logic/oramPkg.sv
// Shared types of the Path ORAM backend
// Commands, buckets, DRAM words and the bucket address walk
`default_nettype none

`include "oram_macros.svh"

package oramPkg;

	typedef struct packed {
		logic write;
		logic [`ORAM_U-1:0] paddr;
		logic [`ORAM_L-1:0] currentLeaf;
		logic [`ORAM_L-1:0] remappedLeaf;
		logic [`ORAM_DW-1:0] storeData;
	} oramCmd_t;

	typedef struct packed {
		logic [`ORAM_AW-1:0] addr;
		logic write;
	} dramCmd_t;

	// Plaintext bucket, Z = 1
	typedef struct packed {
		logic valid;
		logic [`ORAM_U-1:0] paddr;
		logic [`ORAM_L-1:0] leaf;
		logic [`ORAM_DW-1:0] data;
	} bucket_t;

	// Same DRAM word as a bucket or as ciphertext
	typedef union packed {
		bucket_t bucket;
		logic [$bits(bucket_t)-1:0] raw;
	} dramWord_u;

	// Root is 1, each step down appends the next leaf bit (MSB first)
	function automatic logic [`ORAM_AW-1:0] bucketIdx(input logic [`ORAM_L-1:0] leaf,
			input logic [`ORAM_LW-1:0] lvl);
		logic [`ORAM_AW-1:0] idx;
		idx = '0;
		idx[0] = 1'b1;
		for (int i = 0; i < `ORAM_L; i++) begin
			if (i < int'(lvl))
				idx = {idx[`ORAM_AW-2:0], leaf[`ORAM_L-1-i]};
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: logic/pathAddrGen.sv
// Path ORAM address generation
// Takes one command, reads the path root to leaf, then writes it back leaf to root
`timescale 1ns/100ps
`default_nettype none

`include "oram_macros.svh"

module pathAddrGen (
	input  wire                       Clock,
	input  wire                       arstN,
	input  wire oramPkg::oramCmd_t    Command,
	input  wire                       CommandValid,
	output logic                      CommandReady,
	output oramPkg::oramCmd_t         activeCmd,
	output oramPkg::dramCmd_t         DRAMCommand,
	output logic                      DRAMCommandValid,
	input  wire                       DRAMCommandReady,
	input  wire                       readWordSeen,
	output logic                      readLevel,
	output logic                      writeLevel,
	output logic [`ORAM_LW-1:0]       level,
	output logic                      evictNow,
	output logic                      writeReq,
	input  wire                       writeDone,
	output logic                      pathDone
);

	localparam logic [`ORAM_LW-1:0] LeafLevel = `ORAM_L;
	localparam logic [`ORAM_LW:0] PathLen = `ORAM_L + 1;

	typedef enum logic [2:0] {idle, readIssue, readWait, serve, writeCmd, writeData} state_t;

	state_t state;
	// Read issue index, reused as the write level on the way up
	logic [`ORAM_LW-1:0] issueCnt;
	// Read words back from DRAM
	logic [`ORAM_LW:0] wordCnt;
	logic reqSent;
	logic writePhase;

	assign CommandReady = (state == idle);
	assign writePhase = (state == writeCmd) || (state == writeData);
	assign readLevel = (state == readIssue) || (state == readWait);
	assign writeLevel = writePhase;
	assign pathDone = (state == serve);

	// Read side follows the returning words, write side the walk up
	assign level = writePhase ? issueCnt : wordCnt[`ORAM_LW-1:0];

	assign DRAMCommandValid = (state == readIssue) || (state == writeCmd);
	assign DRAMCommand = '{addr: oramPkg::bucketIdx(activeCmd.currentLeaf, issueCnt),
		write: writePhase};

	// Victim is picked as the write command goes out
	assign evictNow = (state == writeCmd) && DRAMCommandReady;
	assign writeReq = (state == writeData) && !reqSent;

	always_ff @(posedge Clock) begin
		if (CommandReady && CommandValid)
			activeCmd <= Command;
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			issueCnt <= '0;
			wordCnt <= '0;
			reqSent <= 1'b0;
		end else begin
			if (readLevel && readWordSeen)
				wordCnt <= wordCnt + 1'b1;
			case (state)
				idle: begin
					if (CommandValid) begin
						issueCnt <= '0;
						wordCnt <= '0;
						state <= readIssue;
					end
				end
				readIssue: begin
					if (DRAMCommandReady) begin
						if (issueCnt == LeafLevel)
							state <= readWait;
						else
							issueCnt <= issueCnt + 1'b1;
					end
				end
				// Last word still needs a cycle in the stash
				readWait: begin
					if (wordCnt == PathLen)
						state <= serve;
				end
				serve: begin
					issueCnt <= LeafLevel;
					state <= writeCmd;
				end
				writeCmd: begin
					if (DRAMCommandReady) begin
						reqSent <= 1'b0;
						state <= writeData;
					end
				end
				writeData: begin
					reqSent <= 1'b1;
					if (writeDone) begin
						reqSent <= 1'b0;
						if (issueCnt == '0) begin
							state <= idle;
						end else begin
							issueCnt <= issueCnt - 1'b1;
							state <= writeCmd;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire
